// ==== dv/eye_locator_cases.txt ====
# name x0 y0 w h hole_x0 hole_y0 hole_w hole_h block_found eye_found gaps
# w 0 gives an all black frame, hole_w 0 means no hole, gaps 1 adds idle cycles
empty        0   0   0  0    0   0  0  0  0 0 0
solid_40   100 100  40 40    0   0  0  0  1 1 0
holed      200 150  40 80  209 190 22 26  1 1 0
rearm_a    300  60  40 40    0   0  0  0  1 1 0
rearm_b    300  60  40 40    0   0  0  0  1 1 0
small_20   400 200  20 20    0   0  0  0  0 0 0
hole_kills 500 100  40 40  509 107 22 26  0 0 0
right_edge 700 300  60 40    0   0  0  0  1 1 0
gaps_solid 100 100  40 40    0   0  0  0  1 1 1
gaps_holed 200 150  40 80  209 190 22 26  1 1 1
gaps_rearm 300  60  40 40    0   0  0  0  1 1 1

// ==== src.f ====
logic/eye_locator_pkg.sv
logic/line_buffer.sv
logic/bin_window.sv
logic/window_popcount.sv
logic/feature_search_fsm.sv
logic/eye_locator_top.sv
dv/eye_locator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the eye locator testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f src.f \
  --top-module eye_locator_tb -Mdir obj_dir -o eye_locator_sim

./obj_dir/eye_locator_sim | tee sim.log

if grep -q "TEST FAILED" sim.log
then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// ==== dv/eye_locator_tb.sv ====
`timescale 1ns/100ps

module eye_locator_tb
  import eye_locator_pkg::*;
();

  localparam int          FRAME_H   = 480;
  localparam int          FRAME_PIX = FRAME_H * LINE_LEN;
  localparam int          MAX_CASES = 32;
  localparam int          SETTLE    = 10;
  localparam int          BIT_HIST  = 32768;
  localparam int          COL_HIST  = 1024;
  localparam logic [31:0] SEED      = 32'd97941;

  logic   iCLK;
  logic   iRST_N;
  pix_t   pix;
  logic   load;
  coord_t block_pos;
  coord_t eye_pos;

  bit     frame [FRAME_H][LINE_LEN];
  // fields: x0 y0 w h hole_x0 hole_y0 hole_w hole_h block eye gaps
  string  case_name [MAX_CASES];
  int     case_par [MAX_CASES][11];
  int     num_cases;

  // running window count over the pixel stream
  bit     bit_hist [BIT_HIST];
  int     col_hist [COL_HIST];
  int     stream_pos;
  int     win_count;

  // reference search state
  bit     ref_eye_mode;
  bit     ref_armed;
  int     ref_block_x, ref_block_y;
  int     ref_eye_x, ref_eye_y;
  int     ref_loads;
  int     ref_eyes;

  logic [31:0] rng_state;
  int     load_total = 0;
  int     cycles = 0;
  int     cycle_limit = 0;
  int     errors;
  int     checks;

  eye_locator_top u_dut (
    .iCLK      (iCLK),
    .iRST_N    (iRST_N),
    .pix       (pix),
    .load      (load),
    .block_pos (block_pos),
    .eye_pos   (eye_pos)
  );

  always #20 iCLK = ~iCLK;

  always @(negedge iCLK)
  begin
    if (iRST_N && load === 1'b1)
      load_total = load_total + 1;
  end

  always @(posedge iCLK)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles, the frames did not complete", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // mostly no gap, now and then 1 to 4 idle cycles
  function automatic int draw_gap();
    logic [31:0] r;
    r = xorshift32();
    if (r[3:0] != 4'd0)
      return 0;
    return 1 + int'(r[9:8]);
  endfunction

  function automatic int cycle_budget();
    int total;
    total = num_cases * FRAME_PIX + 1000;
    for (int i = 0; i < num_cases; i++)
    begin
      if (case_par[i][10] != 0)
      begin
        for (int p = 0; p < FRAME_PIX; p++)
          total += draw_gap();
      end
    end
    rng_state = SEED;
    return total;
  endfunction

  task automatic read_cases();
    int    fd;
    int    n;
    string line;
    string name;
    int    v [11];
    fd = $fopen("dv/eye_locator_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open dv/eye_locator_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name, v[0], v[1], v[2],
                  v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
      if (n == 12 && num_cases < MAX_CASES)
      begin
        case_name[num_cases] = name;
        case_par[num_cases] = v;
        num_cases++;
      end
    end
    $fclose(fd);
  endtask

  task automatic build_frame(int idx);
    int x0;
    int y0;
    int w;
    int h;
    x0 = case_par[idx][0];
    y0 = case_par[idx][1];
    w = case_par[idx][2];
    h = case_par[idx][3];
    for (int y = 0; y < FRAME_H; y++)
      for (int x = 0; x < LINE_LEN; x++)
        frame[y][x] = 1'b0;
    if (w == 0)
      return;
    if (x0 <= WIN_COLS || x0 + w - 1 > LINE_LEN - WIN_COLS || y0 < WIN_ROWS
        || y0 + h - 1 >= FRAME_H - WIN_ROWS)
    begin
      $display("case %s has a rectangle inside the black border", case_name[idx]);
      errors++;
    end
    for (int y = y0; y < y0 + h; y++)
      for (int x = x0; x < x0 + w; x++)
        frame[y][x-1] = 1'b1;
    for (int y = case_par[idx][5]; y < case_par[idx][5] + case_par[idx][7]; y++)
      for (int x = case_par[idx][4]; x < case_par[idx][4] + case_par[idx][6]; x++)
        frame[y][x-1] = 1'b0;
  endtask

  // window count by running sums, then the search rules
  task automatic model_step(int x, int y, bit b);
    int col_sum;
    int old_col;
    col_sum = int'(b);
    if (stream_pos >= LINE_LEN)
      col_sum += col_hist[(stream_pos - LINE_LEN) % COL_HIST];
    if (stream_pos >= WIN_ROWS * LINE_LEN)
      col_sum -= int'(bit_hist[(stream_pos - WIN_ROWS * LINE_LEN) % BIT_HIST]);
    old_col = 0;
    if (stream_pos >= WIN_COLS)
      old_col = col_hist[(stream_pos - WIN_COLS) % COL_HIST];
    win_count = win_count + col_sum - old_col;
    bit_hist[stream_pos % BIT_HIST] = b;
    col_hist[stream_pos % COL_HIST] = col_sum;
    stream_pos++;
    if (!ref_eye_mode)
    begin
      if (y < TOP_ROWS)
        ref_armed = 1'b0;
      else if (x >= 1 && x <= BLOCK_X_MAX && win_count > BLOCK_MIN && !ref_armed)
      begin
        ref_loads++;
        ref_block_x = x;
        ref_block_y = y;
        ref_armed = 1'b1;
        ref_eye_mode = 1'b1;
      end
    end
    else if (y >= TOP_ROWS && x >= 1 && x <= EYE_X_MAX && win_count < EYE_MAX)
    begin
      ref_eyes++;
      ref_eye_x = x;
      ref_eye_y = y;
      ref_eye_mode = 1'b0;
    end
  endtask

  task automatic stream_frame(bit gaps);
    int g;
    for (int y = 0; y < FRAME_H; y++)
    begin
      for (int x = 1; x <= LINE_LEN; x++)
      begin
        @(posedge iCLK);
        #2;
        pix = '{dval: 1'b1, wb: frame[y][x-1], x: X_W'(x), y: Y_W'(y)};
        model_step(x, y, frame[y][x-1]);
        g = gaps ? draw_gap() : 0;
        repeat (g)
        begin
          @(posedge iCLK);
          #2;
          pix.dval = 1'b0;
        end
      end
    end
    @(posedge iCLK);
    #2;
    pix.dval = 1'b0;
  endtask

  task automatic check_value(string name, string what, int exp, int act);
    checks++;
    if (exp != act)
    begin
      errors++;
      $display("MISMATCH %s %s expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic check_pos(string name, string what, int ex, int ey, coord_t act);
    checks++;
    if (ex != int'(act.x) || ey != int'(act.y))
    begin
      errors++;
      $display("MISMATCH %s %s expected (%0d,%0d) actual (%0d,%0d)", name, what, ex, ey,
               int'(act.x), int'(act.y));
    end
  endtask

  task automatic run_case(int idx);
    int loads_before;
    int ref_before;
    int eyes_before;
    int seen;
    build_frame(idx);
    loads_before = load_total;
    ref_before = ref_loads;
    eyes_before = ref_eyes;
    stream_frame(case_par[idx][10] != 0);
    repeat (SETTLE) @(posedge iCLK);
    @(negedge iCLK);
    seen = load_total - loads_before;
    check_value(case_name[idx], "load pulses", ref_loads - ref_before, seen);
    check_value(case_name[idx], "block found", case_par[idx][8], seen > 0 ? 1 : 0);
    check_value(case_name[idx], "eye found", case_par[idx][9], ref_eyes > eyes_before ? 1 : 0);
    check_pos(case_name[idx], "block_pos", ref_block_x, ref_block_y, block_pos);
    check_pos(case_name[idx], "eye_pos", ref_eye_x, ref_eye_y, eye_pos);
  endtask

  initial
  begin
    iCLK = 1'b0;
    iRST_N = 1'b0;
    pix = '0;
    errors = 0;
    checks = 0;
    num_cases = 0;
    stream_pos = 0;
    win_count = 0;
    rng_state = SEED;
    ref_eye_mode = 1'b0;
    ref_armed = 1'b0;
    ref_loads = 0;
    ref_eyes = 0;
    ref_block_x = BLOCK_X_RST;
    ref_block_y = BLOCK_Y_RST;
    ref_eye_x = EYE_X_RST;
    ref_eye_y = EYE_Y_RST;
    read_cases();
    if (num_cases == 0)
    begin
      $display("no test frames were read from the case file");
      errors++;
    end
    cycle_limit = cycle_budget();
    repeat (2) @(posedge iCLK);
    #2;
    iRST_N = 1'b1;
    for (int i = 0; i < num_cases; i++)
      run_case(i);
    $display("frames %0d, checks %0d, errors %0d", num_cases, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== logic/eye_locator_top.sv ====
`timescale 1ns/100ps

module eye_locator_top
  import eye_locator_pkg::*;
(
  input  logic   iCLK,
  input  logic   iRST_N,
  input  pix_t   pix,
  output logic   load,
  output coord_t block_pos,
  output coord_t eye_pos
);

  col_t col;
  win_t win;
  sum_t sum;

  line_buffer u_line_buffer (
    .iCLK   (iCLK),
    .iRST_N (iRST_N),
    .pix    (pix),
    .col    (col)
  );

  bin_window u_bin_window (
    .iCLK   (iCLK),
    .iRST_N (iRST_N),
    .col    (col),
    .win    (win)
  );

  window_popcount u_window_popcount (
    .iCLK   (iCLK),
    .iRST_N (iRST_N),
    .win    (win),
    .sum    (sum)
  );

  feature_search_fsm u_feature_search_fsm (
    .iCLK      (iCLK),
    .iRST_N    (iRST_N),
    .sum       (sum),
    .load      (load),
    .block_pos (block_pos),
    .eye_pos   (eye_pos)
  );

endmodule

// ==== logic/feature_search_fsm.sv ====
`timescale 1ns/100ps

module feature_search_fsm
  import eye_locator_pkg::*;
(
  input  logic   iCLK,
  input  logic   iRST_N,
  input  sum_t   sum,
  output logic   load,
  output coord_t block_pos,
  output coord_t eye_pos
);

  search_state_e state_q;
  search_state_e state_d;
  // set once a block is taken, cleared at the frame top
  logic          arm_q;
  logic          arm_d;
  logic          load_d;
  logic          eye_we;
  logic          top_row;
  logic          block_hit;
  logic          eye_hit;
  coord_t        block_pos_q;
  coord_t        eye_pos_q;

  assign top_row = sum.pos.y < Y_W'(TOP_ROWS);

  assign block_hit = sum.valid
                  && (sum.pos.x >= X_W'(1))
                  && (sum.pos.x <= X_W'(BLOCK_X_MAX))
                  && (sum.count > SUM_W'(BLOCK_MIN));

  assign eye_hit = sum.valid
                && !top_row
                && (sum.pos.x >= X_W'(1))
                && (sum.pos.x <= X_W'(EYE_X_MAX))
                && (sum.count < SUM_W'(EYE_MAX));

  always_comb
  begin
    state_d = state_q;
    arm_d   = arm_q;
    load_d  = 1'b0;
    eye_we  = 1'b0;
    case (state_q)
      SEARCH_IDLE:
      begin
        state_d = SEARCH_BLOCK;
      end
      SEARCH_BLOCK:
      begin
        if (top_row)
        begin
          arm_d = 1'b0;
        end
        else if (block_hit && !arm_q)
        begin
          load_d  = 1'b1;
          arm_d   = 1'b1;
          state_d = SEARCH_EYE;
        end
      end
      SEARCH_EYE:
      begin
        // no timeout, the eye search may span frames
        if (eye_hit)
        begin
          eye_we  = 1'b1;
          state_d = SEARCH_BLOCK;
        end
      end
      default:
      begin
        state_d = SEARCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge iCLK or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      state_q <= SEARCH_IDLE;
      arm_q   <= 1'b0;
      load    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      arm_q   <= arm_d;
      load    <= load_d;
    end
  end

  // defaults are loaded from idle
  always_ff @(posedge iCLK)
  begin
    if (state_q == SEARCH_IDLE)
    begin
      block_pos_q <= '{x: X_W'(BLOCK_X_RST), y: Y_W'(BLOCK_Y_RST)};
      eye_pos_q   <= '{x: X_W'(EYE_X_RST), y: Y_W'(EYE_Y_RST)};
    end
    else
    begin
      if (load_d)
      begin
        block_pos_q <= sum.pos;
      end
      if (eye_we)
      begin
        eye_pos_q <= sum.pos;
      end
    end
  end

  assign block_pos = block_pos_q;
  assign eye_pos   = eye_pos_q;

endmodule

// ==== logic/window_popcount.sv ====
`timescale 1ns/100ps

module window_popcount
  import eye_locator_pkg::*;
(
  input  logic iCLK,
  input  logic iRST_N,
  input  win_t win,
  output sum_t sum
);

  logic [WIN_COLS-1:0][COL_CNT_W-1:0] col_cnt_d;
  logic [WIN_COLS-1:0][COL_CNT_W-1:0] col_cnt_q;
  logic [SUM_W-1:0]                   total_d;
  logic [SUM_W-1:0]                   total_q;
  logic                               vld1_q;
  logic                               vld2_q;
  coord_t                             pos1_q;
  coord_t                             pos2_q;

  // stage one, white pixels per column
  always_comb
  begin
    col_cnt_d = '0;
    for (int c = 0; c < WIN_COLS; c++)
    begin
      for (int r = 0; r < WIN_ROWS; r++)
      begin
        col_cnt_d[c] = col_cnt_d[c] + COL_CNT_W'(win.bits[c][r]);
      end
    end
  end

  // stage two, add the column counts
  always_comb
  begin
    total_d = '0;
    for (int c = 0; c < WIN_COLS; c++)
    begin
      total_d = total_d + SUM_W'(col_cnt_q[c]);
    end
  end

  always_ff @(posedge iCLK or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end
    else
    begin
      vld1_q <= win.valid;
      vld2_q <= vld1_q;
    end
  end

  always_ff @(posedge iCLK)
  begin
    col_cnt_q <= col_cnt_d;
    pos1_q    <= win.pos;
    total_q   <= total_d;
    pos2_q    <= pos1_q;
  end

  assign sum = '{
    valid: vld2_q,
    count: total_q,
    pos:   pos2_q
  };

endmodule

// ==== logic/bin_window.sv ====
`timescale 1ns/100ps

module bin_window
  import eye_locator_pkg::*;
(
  input  logic iCLK,
  input  logic iRST_N,
  input  col_t col,
  output win_t win
);

  // column 0 is the newest
  logic [WIN_COLS-1:0][WIN_ROWS-1:0] win_bits_q;
  logic                              win_vld_q;
  coord_t                            pos_q;

  always_ff @(posedge iCLK or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      win_bits_q <= '0;
      win_vld_q  <= 1'b0;
    end
    else
    begin
      win_vld_q <= col.pix.dval;
      // idle cycles hold the window
      if (col.pix.dval)
      begin
        win_bits_q <= {win_bits_q[WIN_COLS-2:0], col.bits};
      end
    end
  end

  always_ff @(posedge iCLK)
  begin
    if (col.pix.dval)
    begin
      pos_q <= '{x: col.pix.x, y: col.pix.y};
    end
  end

  assign win = '{
    bits:  win_bits_q,
    valid: win_vld_q,
    pos:   pos_q
  };

endmodule

// ==== logic/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer
  import eye_locator_pkg::*;
(
  input  logic iCLK,
  input  logic iRST_N,
  input  pix_t pix,
  output col_t col
);

  // one word per stream position holds the previous 23 lines
  logic [WIN_ROWS-2:0]   mem [LINE_LEN];
  logic [WIN_ROWS-2:0]   old_bits;
  logic [LINE_PTR_W-1:0] wr_ptr;
  logic [WIN_ROWS-1:0]   col_bits_q;
  logic                  col_vld_q;
  coord_t                pos_q;

  assign old_bits = mem[wr_ptr];

  // control state
  always_ff @(posedge iCLK or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      wr_ptr    <= '0;
      col_vld_q <= 1'b0;
    end
    else
    begin
      col_vld_q <= pix.dval;
      if (pix.dval)
      begin
        if (wr_ptr == LINE_PTR_W'(LINE_LEN - 1))
        begin
          wr_ptr <= '0;
        end
        else
        begin
          wr_ptr <= wr_ptr + LINE_PTR_W'(1);
        end
      end
    end
  end

  // read old rows and write them back one line up
  always_ff @(posedge iCLK)
  begin
    if (pix.dval)
    begin
      mem[wr_ptr] <= {old_bits[WIN_ROWS-3:0], pix.wb};
      col_bits_q  <= {old_bits, pix.wb};
      pos_q       <= '{x: pix.x, y: pix.y};
    end
  end

  assign col = '{
    bits: col_bits_q,
    pix:  '{dval: col_vld_q, wb: col_bits_q[0], x: pos_q.x, y: pos_q.y}
  };

endmodule

// ==== logic/eye_locator_pkg.sv ====
package eye_locator_pkg;

  // pixel coordinate widths
  localparam int X_W = 11;
  localparam int Y_W = 10;

  // valid pixels per line, x runs 1..LINE_LEN
  localparam int LINE_LEN   = 800;
  localparam int LINE_PTR_W = $clog2(LINE_LEN);

  // window geometry
  localparam int WIN_ROWS  = 24;
  localparam int WIN_COLS  = 19;
  localparam int COL_CNT_W = $clog2(WIN_ROWS + 1);
  localparam int SUM_W     = 9;

  // search thresholds and limits
  localparam int BLOCK_MIN   = 400;
  localparam int EYE_MAX     = 50;
  localparam int TOP_ROWS    = 10;
  localparam int BLOCK_X_MAX = 800;
  localparam int EYE_X_MAX   = 700;

  // coordinate register defaults
  localparam int BLOCK_X_RST = 400;
  localparam int BLOCK_Y_RST = 240;
  localparam int EYE_X_RST   = 20;
  localparam int EYE_Y_RST   = 24;

  typedef struct packed {
    logic           dval;
    logic           wb;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } pix_t;

  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } coord_t;

  // bit 0 is the current line, bit WIN_ROWS-1 the oldest
  typedef struct packed {
    logic [WIN_ROWS-1:0] bits;
    pix_t                pix;
  } col_t;

  typedef struct packed {
    logic [WIN_COLS-1:0][WIN_ROWS-1:0] bits;
    logic                              valid;
    coord_t                            pos;
  } win_t;

  typedef struct packed {
    logic             valid;
    logic [SUM_W-1:0] count;
    coord_t           pos;
  } sum_t;

  typedef enum logic [1:0] {
    SEARCH_IDLE,
    SEARCH_BLOCK,
    SEARCH_EYE
  } search_state_e;

endpackage
